// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_virtio_mmio -f vlog.f \
	-o tb_virtio_mmio \
	&& ./obj_dir/tb_virtio_mmio | tee /dev/stderr | grep -q "^TB PASSED$" \
	&& echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }

// File: sim/tb_virtio_mmio.sv
`timescale 1ns/1ps

module tb_virtio_mmio
	import virtio_mmio_pkg::*;
();

	localparam int ID_W           = 1;
	localparam int QUEUE_NUM      = 1;
	localparam int TIMEOUT_CYCLES = 200;
	localparam int MAX_ROWS       = 48;
	localparam int MAX_BEATS      = 8;
	localparam bit WR             = 1'b1;
	localparam bit RD             = 1'b0;

	// identity values of a virtio-mmio block device
	localparam data_t EXP_MAGIC  = 32'h7472_6976;
	localparam data_t EXP_VENDOR = 32'hff00_1af4;

	logic            axi_aclk;
	logic            axi_aresetn;
	logic [ID_W-1:0] awid;
	addr_t           awaddr;
	len_t            awlen;
	burst_e          awburst;
	logic            awvalid;
	logic            awready;
	data_t           wdata;
	logic            wlast;
	logic            wvalid;
	logic            wready;
	logic [ID_W-1:0] bid;
	resp_e           bresp;
	logic            bvalid;
	logic            bready;
	logic [ID_W-1:0] arid;
	addr_t           araddr;
	len_t            arlen;
	burst_e          arburst;
	logic            arvalid;
	logic            arready;
	logic [ID_W-1:0] rid;
	data_t           rdata;
	resp_e           rresp;
	logic            rlast;
	logic            rvalid;
	logic            rready;
	logic            interrupt;

	int     data_errors;
	int     resp_errors;
	int     bit_errors;
	int     state_errors;
	int     timeout_errors;
	int     total_errors;
	integer seed;
	int     r;
	int     b;

	// stimulus table, one access per row
	string      row_name      [MAX_ROWS];
	bit         row_write     [MAX_ROWS];
	addr_t      row_addr      [MAX_ROWS];
	burst_e     row_burst     [MAX_ROWS];
	len_t       row_len       [MAX_ROWS];
	data_t      row_wdata     [MAX_ROWS][MAX_BEATS];
	data_t      row_rdata     [MAX_ROWS][MAX_BEATS];
	logic       row_irq       [MAX_ROWS];
	dev_state_e row_state     [MAX_ROWS];
	bit         row_has_state [MAX_ROWS];
	int         row_count;

	// beats of the burst in progress on each channel
	data_t  wr_beats [MAX_BEATS];
	data_t  rd_exp   [MAX_BEATS];
	data_t  q_words  [6];

	virtio_mmio_top #(.ID_W(ID_W), .QUEUE_NUM(QUEUE_NUM)) i_virtio_mmio_top (.*);

	initial
	begin
		axi_aclk = 1'b0;
		forever
			#10 axi_aclk = ~axi_aclk;
	end

	// ----------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------
	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp)
		begin
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
			data_errors++;
		end
	endtask

	task automatic check_resp(input string name, input resp_e exp, input resp_e act);
		if (act !== exp)
		begin
			$display("Mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
			resp_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
			bit_errors++;
		end
	endtask

	task automatic check_state(input string name, input dev_state_e exp, input dev_state_e act);
		if (act !== exp)
		begin
			$display("Mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
			state_errors++;
		end
	endtask

	task automatic report_timeout(input string what, input string name);
		$display("Timeout: %s never came during %s", what, name);
		timeout_errors++;
	endtask

	function automatic data_t draw_word();
		data_t word;
		word = $random(seed);
		return word;
	endfunction

	// mostly low, so rready stalls come in stretches
	function automatic logic draw_rready();
		data_t word;
		word = $random(seed);
		return (word[1:0] == 2'b00);
	endfunction

	// ----------------------------------------------------------
	// AXI bus tasks
	// ----------------------------------------------------------
	task automatic axi_write(input string name, input addr_t addr, input burst_e burst,
		input len_t len, input logic [ID_W-1:0] id);
		int waited;
		int beat;
		awid    <= id;
		awaddr  <= addr;
		awlen   <= len;
		awburst <= burst;
		awvalid <= 1'b1;
		waited = 0;
		do
		begin
			@(posedge axi_aclk);
			waited++;
		end
		while (!awready && waited < TIMEOUT_CYCLES);
		awvalid <= 1'b0;
		if (!awready)
		begin
			report_timeout("awready", name);
			return;
		end
		// one beat per wready pulse
		for (beat = 0; beat <= int'(len); beat++)
		begin
			wdata  <= wr_beats[beat];
			wlast  <= (beat == int'(len));
			wvalid <= 1'b1;
			waited = 0;
			do
			begin
				@(posedge axi_aclk);
				waited++;
			end
			while (!wready && waited < TIMEOUT_CYCLES);
			if (!wready)
			begin
				wvalid <= 1'b0;
				wlast  <= 1'b0;
				report_timeout("wready", name);
				return;
			end
		end
		wvalid <= 1'b0;
		wlast  <= 1'b0;
		bready <= 1'b1;
		waited = 0;
		do
		begin
			@(posedge axi_aclk);
			waited++;
		end
		while (!bvalid && waited < TIMEOUT_CYCLES);
		bready <= 1'b0;
		if (!bvalid)
			report_timeout("bvalid", name);
		else
		begin
			check_resp({name, " bresp"}, OKAY, bresp);
			check_bit({name, " bid"}, id[0], bid[0]);
		end
	endtask

	task automatic axi_read(input string name, input addr_t addr, input burst_e burst,
		input len_t len, input logic [ID_W-1:0] id, input bit stall);
		int   waited;
		int   beat;
		logic taken;
		arid    <= id;
		araddr  <= addr;
		arlen   <= len;
		arburst <= burst;
		arvalid <= 1'b1;
		waited = 0;
		do
		begin
			@(posedge axi_aclk);
			waited++;
		end
		while (!arready && waited < TIMEOUT_CYCLES);
		arvalid <= 1'b0;
		if (!arready)
		begin
			report_timeout("arready", name);
			return;
		end
		rready <= stall ? draw_rready() : 1'b1;
		for (beat = 0; beat <= int'(len); beat++)
		begin
			waited = 0;
			do
			begin
				@(posedge axi_aclk);
				waited++;
				taken = rvalid && rready;
				if (!taken)
					rready <= stall ? draw_rready() : 1'b1;
			end
			while (!taken && waited < TIMEOUT_CYCLES);
			if (!taken)
			begin
				rready <= 1'b0;
				report_timeout("R beat", name);
				return;
			end
			check_data($sformatf("%s beat %0d", name, beat), rd_exp[beat], rdata);
			check_resp({name, " rresp"}, OKAY, rresp);
			check_bit($sformatf("%s rlast %0d", name, beat), beat == int'(len), rlast);
			check_bit({name, " rid"}, id[0], rid[0]);
			if (stall)
				rready <= draw_rready();
		end
		rready <= 1'b0;
	endtask

	// ----------------------------------------------------------
	// stimulus table
	// ----------------------------------------------------------
	task automatic add_row(input string name, input bit write, input addr_t addr,
		input burst_e burst, input len_t len, input data_t d0, input data_t d1,
		input data_t d2, input logic irq);
		int i;
		row_name[row_count]      = name;
		row_write[row_count]     = write;
		row_addr[row_count]      = addr;
		row_burst[row_count]     = burst;
		row_len[row_count]       = len;
		row_irq[row_count]       = irq;
		row_state[row_count]     = DEV_RESET;
		row_has_state[row_count] = 1'b0;
		for (i = 0; i < MAX_BEATS; i++)
		begin
			row_wdata[row_count][i] = '0;
			row_rdata[row_count][i] = '0;
		end
		if (write)
		begin
			row_wdata[row_count][0] = d0;
			row_wdata[row_count][1] = d1;
			row_wdata[row_count][2] = d2;
		end
		else
		begin
			row_rdata[row_count][0] = d0;
			row_rdata[row_count][1] = d1;
			row_rdata[row_count][2] = d2;
		end
		row_count++;
	endtask

	// setup step expected after the row just added
	task automatic expect_state(input dev_state_e state);
		row_state[row_count-1]     = state;
		row_has_state[row_count-1] = 1'b1;
	endtask

	task automatic build_table();
		int i;
		row_count = 0;
		for (i = 0; i < 6; i++)
			q_words[i] = draw_word();
		add_row("magic", RD, OFF_MAGIC, BURST_INCR, 8'd0, EXP_MAGIC, '0, '0, 1'b0);
		add_row("version", RD, OFF_VERSION, BURST_INCR, 8'd0, 32'd2, '0, '0, 1'b0);
		add_row("device id", RD, OFF_DEVICE_ID, BURST_INCR, 8'd0, 32'd2, '0, '0, 1'b0);
		add_row("vendor id", RD, OFF_VENDOR_ID, BURST_INCR, 8'd0, EXP_VENDOR, '0, '0, 1'b0);
		add_row("queue num max", RD, OFF_QUEUE_NUM_MAX, BURST_INCR, 8'd0, 32'd16, '0, '0, 1'b0);
		add_row("config gen", RD, OFF_CONFIG_GEN, BURST_INCR, 8'd0, '0, '0, '0, 1'b0);
		add_row("capacity lo", RD, OFF_CAPACITY_LO, BURST_INCR, 8'd0, 32'd4, '0, '0, 1'b0);
		add_row("capacity hi", RD, OFF_CAPACITY_HI, BURST_INCR, 8'd0, '0, '0, '0, 1'b0);
		add_row("unknown offset", RD, addr_t'(12'h200), BURST_INCR, 8'd0, '0, '0, '0, 1'b0);
		// feature word halves
		add_row("feature sel 0", WR, OFF_DEV_FEATURES_SEL, BURST_INCR, 8'd0, '0, '0, '0, 1'b0);
		add_row("features low", RD, OFF_DEV_FEATURES, BURST_INCR, 8'd0, '0, '0, '0, 1'b0);
		add_row("feature sel 1", WR, OFF_DEV_FEATURES_SEL, BURST_INCR, 8'd0, 32'd1, '0, '0, 1'b0);
		add_row("features high", RD, OFF_DEV_FEATURES, BURST_INCR, 8'd0, 32'd3, '0, '0, 1'b0);
		// queue 0 addresses
		add_row("desc burst", WR, OFF_DESC_LO, BURST_INCR, 8'd1, q_words[0], q_words[1], '0, 1'b0);
		add_row("driver lo", WR, OFF_DRIVER_LO, BURST_INCR, 8'd0, q_words[2], '0, '0, 1'b0);
		add_row("driver hi", WR, OFF_DRIVER_HI, BURST_INCR, 8'd0, q_words[3], '0, '0, 1'b0);
		add_row("device lo", WR, OFF_DEVICE_LO, BURST_INCR, 8'd0, q_words[4], '0, '0, 1'b0);
		add_row("device hi", WR, OFF_DEVICE_HI, BURST_INCR, 8'd0, q_words[5], '0, '0, 1'b0);
		add_row("queue ready", WR, OFF_QUEUE_READY, BURST_INCR, 8'd0, 32'd1, '0, '0, 1'b0);
		add_row("desc read", RD, OFF_DESC_LO, BURST_INCR, 8'd1, q_words[0], q_words[1], '0, 1'b0);
		add_row("driver read", RD, OFF_DRIVER_LO, BURST_INCR, 8'd1, q_words[2], q_words[3], '0,
			1'b0);
		add_row("device read", RD, OFF_DEVICE_LO, BURST_INCR, 8'd1, q_words[4], q_words[5], '0,
			1'b0);
		add_row("ready read", RD, OFF_QUEUE_READY, BURST_INCR, 8'd0, 32'd1, '0, '0, 1'b0);
		// fixed bursts keep the address, so the last beat picks the queue
		add_row("sel fixed 1", WR, OFF_QUEUE_SEL, BURST_FIXED, 8'd2, 32'd3, 32'd2, 32'd1, 1'b0);
		add_row("ready of queue 1", RD, OFF_QUEUE_READY, BURST_INCR, 8'd0, '0, '0, '0, 1'b0);
		add_row("desc of queue 1", RD, OFF_DESC_LO, BURST_INCR, 8'd0, '0, '0, '0, 1'b0);
		add_row("sel fixed 0", WR, OFF_QUEUE_SEL, BURST_FIXED, 8'd2, 32'd1, 32'd3, '0, 1'b0);
		add_row("ready of queue 0", RD, OFF_QUEUE_READY, BURST_INCR, 8'd0, 32'd1, '0, '0, 1'b0);
		// interrupt
		add_row("notify", WR, OFF_QUEUE_NOTIFY, BURST_INCR, 8'd0, '0, '0, '0, 1'b1);
		add_row("int status set", RD, OFF_INT_STATUS, BURST_INCR, 8'd0, 32'd1, '0, '0, 1'b1);
		add_row("int ack", WR, OFF_INT_ACK, BURST_INCR, 8'd0, 32'd1, '0, '0, 1'b0);
		add_row("int status clear", RD, OFF_INT_STATUS, BURST_INCR, 8'd0, '0, '0, '0, 1'b0);
		// device status handshake
		add_row("status zero", WR, OFF_STATUS, BURST_INCR, 8'd0, '0, '0, '0, 1'b0);
		expect_state(DEV_RESET);
		add_row("status ack", RD, OFF_STATUS, BURST_INCR, 8'd0, 32'd1, '0, '0, 1'b0);
		add_row("status driver", WR, OFF_STATUS, BURST_INCR, 8'd0, 32'd2, '0, '0, 1'b0);
		expect_state(DEV_SETUP_BASE);
		add_row("status base", RD, OFF_STATUS, BURST_INCR, 8'd0, 32'd3, '0, '0, 1'b0);
		add_row("status features", WR, OFF_STATUS, BURST_INCR, 8'd0, 32'd8, '0, '0, 1'b0);
		expect_state(DEV_SETUP_DRIVER);
		add_row("status setup", RD, OFF_STATUS, BURST_INCR, 8'd0, 32'd11, '0, '0, 1'b0);
		add_row("status driver ok", WR, OFF_STATUS, BURST_INCR, 8'd0, 32'd4, '0, '0, 1'b0);
		expect_state(DEV_IDLE);
		add_row("status idle", RD, OFF_STATUS, BURST_INCR, 8'd0, 32'd15, '0, '0, 1'b0);
		add_row("status zero again", WR, OFF_STATUS, BURST_INCR, 8'd0, '0, '0, '0, 1'b0);
		expect_state(DEV_RESET);
		add_row("status ack again", RD, OFF_STATUS, BURST_INCR, 8'd0, 32'd1, '0, '0, 1'b0);
		add_row("early driver ok", WR, OFF_STATUS, BURST_INCR, 8'd0, 32'd4, '0, '0, 1'b0);
		expect_state(DEV_RESET);
		add_row("status unchanged", RD, OFF_STATUS, BURST_INCR, 8'd0, 32'd1, '0, '0, 1'b0);
	endtask

	// long read with stalls while a write burst runs on the other channel
	task automatic concurrent_test();
		int i;
		for (i = 0; i < MAX_BEATS; i++)
			wr_beats[i] = draw_word();
		rd_exp[0] = EXP_MAGIC;
		rd_exp[1] = 32'd2;
		rd_exp[2] = 32'd2;
		rd_exp[3] = EXP_VENDOR;
		rd_exp[4] = 32'd3;
		rd_exp[5] = '0;
		fork
			axi_write("concurrent write", OFF_DEVICE_LO, BURST_FIXED, 8'd7, 1'b1);
			axi_read("concurrent read", OFF_MAGIC, BURST_INCR, 8'd5, 1'b0, 1'b1);
		join
		rd_exp[0] = wr_beats[7];
		axi_read("device lo after burst", OFF_DEVICE_LO, BURST_FIXED, 8'd0, 1'b0, 1'b0);
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial
	begin
		axi_aresetn    = 1'b0;
		awid           = '0;
		awaddr         = '0;
		awlen          = '0;
		awburst        = BURST_INCR;
		awvalid        = 1'b0;
		wdata          = '0;
		wlast          = 1'b0;
		wvalid         = 1'b0;
		bready         = 1'b0;
		arid           = '0;
		araddr         = '0;
		arlen          = '0;
		arburst        = BURST_INCR;
		arvalid        = 1'b0;
		rready         = 1'b0;
		data_errors    = 0;
		resp_errors    = 0;
		bit_errors     = 0;
		state_errors   = 0;
		timeout_errors = 0;
		seed           = 32'ha0b00f15;
		build_table();

		repeat (2) @(posedge axi_aclk);
		axi_aresetn <= 1'b1;
		@(posedge axi_aclk);
		check_bit("reset awready", 1'b0, awready);
		check_bit("reset wready", 1'b0, wready);
		check_bit("reset bvalid", 1'b0, bvalid);
		check_bit("reset arready", 1'b0, arready);
		check_bit("reset rvalid", 1'b0, rvalid);
		check_bit("reset rlast", 1'b0, rlast);
		check_bit("reset interrupt", 1'b0, interrupt);
		check_state("reset state", DEV_RESET, i_virtio_mmio_top.dev_state);

		for (r = 0; r < row_count; r++)
		begin
			for (b = 0; b < MAX_BEATS; b++)
			begin
				wr_beats[b] = row_wdata[r][b];
				rd_exp[b]   = row_rdata[r][b];
			end
			if (row_write[r])
				axi_write(row_name[r], row_addr[r], row_burst[r], row_len[r], r[ID_W-1:0]);
			else
				axi_read(row_name[r], row_addr[r], row_burst[r], row_len[r], r[ID_W-1:0], 1'b0);
			// interrupt lags its status bit by one register
			@(posedge axi_aclk);
			check_bit({row_name[r], " interrupt"}, row_irq[r], interrupt);
			if (row_has_state[r])
				check_state({row_name[r], " state"}, row_state[r],
					i_virtio_mmio_top.dev_state);
		end

		concurrent_test();

		total_errors = data_errors + resp_errors + bit_errors + state_errors + timeout_errors;
		$display("errors: data %0d, resp %0d, bit %0d, state %0d, timeout %0d",
			data_errors, resp_errors, bit_errors, state_errors, timeout_errors);
		if (total_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: source/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine
	import virtio_mmio_pkg::*;
#(
	parameter int ID_W = 1
)
(
	input  logic            axi_aclk,
	input  logic            axi_aresetn,
	input  logic [ID_W-1:0] arid,
	input  addr_t           araddr,
	input  len_t            arlen,
	input  burst_e          arburst,
	input  logic            arvalid,
	output logic            arready,
	output logic [ID_W-1:0] rid,
	output data_t           rdata,
	output resp_e           rresp,
	output logic            rlast,
	output logic            rvalid,
	input  logic            rready,
	output reg_req_t        rd_req,
	output logic            rd_valid,
	input  logic            rd_ready,
	input  data_t           bank_rdata
);

	typedef enum logic [2:0] {R_IDLE, R_ADDR, R_REQ, R_WAIT, R_DATA} rd_state_e;

	rd_state_e state;
	addr_t     beat_addr;
	len_t      beat_len;
	len_t      beat_cnt;
	burst_e    beat_burst;
	logic      next_beat;

	assign rd_valid  = (state == R_REQ);
	assign rd_req    = '{write: 1'b0, addr: beat_addr, data: '0};
	assign rresp     = OKAY;
	// R handshake on a beat that is not the last
	assign next_beat = rvalid && rready && !rlast;

	// one beat in flight: request, wait for bank data, hold until taken
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			state    <= R_IDLE;
			arready  <= 1'b0;
			rvalid   <= 1'b0;
			rlast    <= 1'b0;
			beat_cnt <= '0;
		end
		else
		begin
			case (state)
				R_IDLE:
					if (arvalid)
					begin
						arready  <= 1'b1;
						beat_cnt <= '0;
						state    <= R_ADDR;
					end
				R_ADDR:
				begin
					arready <= 1'b0;
					state   <= R_REQ;
				end
				R_REQ:
					if (rd_ready)
						state <= R_WAIT;
				R_WAIT:
				begin
					rvalid <= 1'b1;
					rlast  <= (beat_cnt == beat_len);
					state  <= R_DATA;
				end
				default:
					if (rready)
					begin
						rvalid   <= 1'b0;
						rlast    <= 1'b0;
						beat_cnt <= beat_cnt + 1'b1;
						state    <= rlast ? R_IDLE : R_REQ;
					end
			endcase
		end
	end

	always_ff @(posedge axi_aclk)
	begin
		if (state == R_IDLE && arvalid)
		begin
			rid        <= arid;
			beat_addr  <= araddr;
			beat_len   <= arlen;
			beat_burst <= arburst;
		end
		else if (next_beat && (beat_burst == BURST_INCR || beat_burst == BURST_WRAP))
			beat_addr <= beat_addr + WORD_BYTES;
		if (state == R_WAIT)
			rdata <= bank_rdata;
	end

endmodule

// File: source/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine
	import virtio_mmio_pkg::*;
#(
	parameter int ID_W = 1
)
(
	input  logic            axi_aclk,
	input  logic            axi_aresetn,
	input  logic [ID_W-1:0] awid,
	input  addr_t           awaddr,
	input  len_t            awlen,
	input  burst_e          awburst,
	input  logic            awvalid,
	output logic            awready,
	input  data_t           wdata,
	input  logic            wlast,
	input  logic            wvalid,
	output logic            wready,
	output logic [ID_W-1:0] bid,
	output resp_e           bresp,
	output logic            bvalid,
	input  logic            bready,
	output reg_req_t        wr_req,
	output logic            wr_valid,
	input  logic            wr_ready
);

	typedef enum logic [1:0] {W_IDLE, W_ADDR, W_DATA, W_RESP} wr_state_e;

	wr_state_e state;
	addr_t     beat_addr;
	len_t      beat_len;
	len_t      beat_cnt;
	burst_e    beat_burst;
	logic      beat_done;
	logic      last_beat;

	// every W beat becomes one register write, granted by the arbiter
	assign wr_valid  = (state == W_DATA) && wvalid;
	assign wr_req    = '{write: 1'b1, addr: beat_addr, data: wdata};
	assign wready    = wr_ready;
	assign beat_done = wr_valid && wr_ready;
	assign last_beat = wlast || (beat_cnt == beat_len);
	assign bresp     = OKAY;

	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			state    <= W_IDLE;
			awready  <= 1'b0;
			bvalid   <= 1'b0;
			beat_cnt <= '0;
		end
		else
		begin
			case (state)
				W_IDLE:
					if (awvalid)
					begin
						awready  <= 1'b1;
						beat_cnt <= '0;
						state    <= W_ADDR;
					end
				W_ADDR:
				begin
					awready <= 1'b0;
					state   <= W_DATA;
				end
				W_DATA:
					if (beat_done)
					begin
						beat_cnt <= beat_cnt + 1'b1;
						if (last_beat)
						begin
							bvalid <= 1'b1;
							state  <= W_RESP;
						end
					end
				default:
					if (bready)
					begin
						bvalid <= 1'b0;
						state  <= W_IDLE;
					end
			endcase
		end
	end

	// burst fields, wrap bursts step like incr
	always_ff @(posedge axi_aclk)
	begin
		if (state == W_IDLE && awvalid)
		begin
			bid        <= awid;
			beat_addr  <= awaddr;
			beat_len   <= awlen;
			beat_burst <= awburst;
		end
		else if (beat_done && (beat_burst == BURST_INCR || beat_burst == BURST_WRAP))
			beat_addr <= beat_addr + WORD_BYTES;
	end

endmodule

// File: source/device_status_fsm.sv
`timescale 1ns/1ps

module device_status_fsm
	import virtio_mmio_pkg::*;
(
	input  logic       axi_aclk,
	input  logic       axi_aresetn,
	input  logic       status_wr,
	input  data_t      status_wdata,
	output data_t      device_status,
	output dev_state_e dev_state
);

	// status bit the current setup step waits for
	int   step_pos;
	logic step_ok;

	always_comb
	begin
		case (dev_state)
			DEV_RESET:        step_pos = STAT_DRIVER;
			DEV_SETUP_BASE:   step_pos = STAT_FEATURES_OK;
			DEV_SETUP_DRIVER: step_pos = STAT_DRIVER_OK;
			default:          step_pos = STAT_ACK;
		endcase
	end

	assign step_ok = (dev_state != DEV_IDLE) && status_wdata[step_pos];

	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			device_status <= '0;
			dev_state     <= DEV_RESET;
		end
		else if (status_wr)
		begin
			// a zero write is the driver's device reset
			if (status_wdata == '0)
			begin
				device_status <= data_t'(1) << STAT_ACK;
				dev_state     <= DEV_RESET;
			end
			else if (step_ok)
			begin
				device_status[step_pos] <= 1'b1;
				dev_state               <= dev_state_e'(dev_state + 2'd1);
			end
		end
	end

endmodule

// File: source/reg_arbiter.sv
`timescale 1ns/1ps

module reg_arbiter
	import virtio_mmio_pkg::*;
(
	input  logic     axi_aclk,
	input  logic     axi_aresetn,
	input  reg_req_t wr_req,
	input  logic     wr_valid,
	output logic     wr_ready,
	input  reg_req_t rd_req,
	input  logic     rd_valid,
	output logic     rd_ready,
	output reg_req_t bank_req,
	output logic     bank_valid
);

	// set when the read side wins the next tie
	logic rd_first;

	assign wr_ready   = wr_valid && !(rd_valid && rd_first);
	assign rd_ready   = rd_valid && !wr_ready;
	assign bank_valid = wr_valid || rd_valid;
	assign bank_req   = wr_ready ? wr_req : rd_req;

	// priority only moves when both sides compete
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			rd_first <= 1'b0;
		else if (wr_valid && rd_valid)
			rd_first <= !rd_first;
	end

endmodule

// File: source/virtio_mmio_pkg.sv
package virtio_mmio_pkg;

	// ---------------------------------------------------------
	// widths
	// ---------------------------------------------------------
	localparam int REG_ADDR_W = 12;
	localparam int DATA_W     = 32;

	typedef logic [REG_ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0]     data_t;
	typedef logic [7:0]            len_t;

	// address step between two beats of a burst
	localparam addr_t WORD_BYTES = addr_t'(DATA_W / 8);

	// ---------------------------------------------------------
	// identity and reset values
	// ---------------------------------------------------------
	localparam data_t       MAGIC_VALUE       = 32'h7472_6976;
	localparam data_t       VERSION           = 32'd2;
	// block device
	localparam data_t       DEVICE_ID         = 32'd2;
	localparam data_t       VENDOR_ID         = 32'hff00_1af4;
	localparam data_t       QUEUE_NUM_MAX     = 32'd16;
	localparam data_t       CONFIG_GENERATION = 32'd0;
	// capacity in 512 byte sectors
	localparam logic [63:0] SECTOR_COUNT      = 64'd4;
	// VERSION_1 and ACCESS_PLATFORM
	localparam logic [63:0] DEVICE_FEATURES   = 64'h0000_0003_0000_0000;

	// ---------------------------------------------------------
	// register map
	// ---------------------------------------------------------
	typedef enum logic [REG_ADDR_W-1:0] {
		OFF_MAGIC            = 12'h000,
		OFF_VERSION          = 12'h004,
		OFF_DEVICE_ID        = 12'h008,
		OFF_VENDOR_ID        = 12'h00c,
		OFF_DEV_FEATURES     = 12'h010,
		OFF_DEV_FEATURES_SEL = 12'h014,
		OFF_QUEUE_SEL        = 12'h030,
		OFF_QUEUE_NUM_MAX    = 12'h034,
		OFF_QUEUE_NUM        = 12'h038,
		OFF_QUEUE_READY      = 12'h044,
		OFF_QUEUE_NOTIFY     = 12'h050,
		OFF_INT_STATUS       = 12'h060,
		OFF_INT_ACK          = 12'h064,
		OFF_STATUS           = 12'h070,
		OFF_DESC_LO          = 12'h080,
		OFF_DESC_HI          = 12'h084,
		OFF_DRIVER_LO        = 12'h090,
		OFF_DRIVER_HI        = 12'h094,
		OFF_DEVICE_LO        = 12'h0a0,
		OFF_DEVICE_HI        = 12'h0a4,
		OFF_CONFIG_GEN       = 12'h0fc,
		OFF_CAPACITY_LO      = 12'h100,
		OFF_CAPACITY_HI      = 12'h104
	} reg_offset_e;

	// device status bits
	localparam int STAT_ACK         = 0;
	localparam int STAT_DRIVER      = 1;
	localparam int STAT_DRIVER_OK   = 2;
	localparam int STAT_FEATURES_OK = 3;

	typedef enum logic [1:0] {DEV_RESET, DEV_SETUP_BASE, DEV_SETUP_DRIVER, DEV_IDLE} dev_state_e;

	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_e;

	typedef enum logic [1:0] {OKAY = 2'b00, EXOKAY, SLVERR, DECERR} resp_e;

	// one register access, as seen by the bank
	typedef struct packed {
		logic  write;
		addr_t addr;
		data_t data;
	} reg_req_t;

endpackage

// File: source/virtio_mmio_top.sv
`timescale 1ns/1ps

module virtio_mmio_top
	import virtio_mmio_pkg::*;
#(
	parameter int ID_W      = 1,
	parameter int QUEUE_NUM = 1
)
(
	input  logic            axi_aclk,
	input  logic            axi_aresetn,
	// write channels
	input  logic [ID_W-1:0] awid,
	input  addr_t           awaddr,
	input  len_t            awlen,
	input  burst_e          awburst,
	input  logic            awvalid,
	output logic            awready,
	input  data_t           wdata,
	input  logic            wlast,
	input  logic            wvalid,
	output logic            wready,
	output logic [ID_W-1:0] bid,
	output resp_e           bresp,
	output logic            bvalid,
	input  logic            bready,
	// read channels
	input  logic [ID_W-1:0] arid,
	input  addr_t           araddr,
	input  len_t            arlen,
	input  burst_e          arburst,
	input  logic            arvalid,
	output logic            arready,
	output logic [ID_W-1:0] rid,
	output data_t           rdata,
	output resp_e           rresp,
	output logic            rlast,
	output logic            rvalid,
	input  logic            rready,
	output logic            interrupt
);

	reg_req_t   wr_req;
	logic       wr_valid;
	logic       wr_ready;
	reg_req_t   rd_req;
	logic       rd_valid;
	logic       rd_ready;
	reg_req_t   bank_req;
	logic       bank_valid;
	data_t      bank_rdata;
	logic       status_wr;
	data_t      status_wdata;
	data_t      device_status;
	dev_state_e dev_state;

	axi_write_engine #(.ID_W(ID_W)) i_axi_write_engine (.*);

	axi_read_engine #(.ID_W(ID_W)) i_axi_read_engine (.*);

	// both channel engines share the one register bank
	reg_arbiter i_reg_arbiter (.*);

	virtio_regs #(.QUEUE_NUM(QUEUE_NUM)) i_virtio_regs (.*);

	device_status_fsm i_device_status_fsm (.*);

endmodule

// File: source/virtio_regs.sv
`timescale 1ns/1ps

module virtio_regs
	import virtio_mmio_pkg::*;
#(
	parameter int QUEUE_NUM = 1
)
(
	input  logic     axi_aclk,
	input  logic     axi_aresetn,
	input  reg_req_t bank_req,
	input  logic     bank_valid,
	output data_t    bank_rdata,
	output logic     status_wr,
	output data_t    status_wdata,
	input  data_t    device_status,
	output logic     interrupt
);

	localparam int QIDX_W = (QUEUE_NUM > 1) ? $clog2(QUEUE_NUM) : 1;

	data_t             feature_sel;
	data_t             queue_sel;
	data_t             queue_num;
	data_t             int_status;
	// ready, desc lo/hi, driver lo/hi, device lo/hi
	data_t             queue_tab [QUEUE_NUM][7];
	logic [QIDX_W-1:0] sel_idx;
	logic              sel_ok;
	logic [2:0]        slot;
	logic              slot_hit;
	data_t             slot_data;
	data_t             feature_word;
	data_t             rd_value;
	logic              wr_en;
	logic              rd_en;

	assign wr_en   = bank_valid && bank_req.write;
	assign rd_en   = bank_valid && !bank_req.write;
	assign sel_ok  = queue_sel < data_t'(QUEUE_NUM);
	assign sel_idx = queue_sel[QIDX_W-1:0];

	assign status_wr    = wr_en && (bank_req.addr == OFF_STATUS);
	assign status_wdata = bank_req.data;

	// ---------------------------------------------------------
	// queue table slot of the selected queue
	// ---------------------------------------------------------
	always_comb
	begin
		slot     = 3'd0;
		slot_hit = 1'b1;
		case (bank_req.addr)
			OFF_QUEUE_READY: slot = 3'd0;
			OFF_DESC_LO:     slot = 3'd1;
			OFF_DESC_HI:     slot = 3'd2;
			OFF_DRIVER_LO:   slot = 3'd3;
			OFF_DRIVER_HI:   slot = 3'd4;
			OFF_DEVICE_LO:   slot = 3'd5;
			OFF_DEVICE_HI:   slot = 3'd6;
			default:         slot_hit = 1'b0;
		endcase
	end

	assign slot_data    = (slot_hit && sel_ok) ? queue_tab[sel_idx][slot] : '0;
	assign feature_word = (feature_sel == '0) ? DEVICE_FEATURES[31:0] :
		(feature_sel == data_t'(1)) ? DEVICE_FEATURES[63:32] : '0;

	// ---------------------------------------------------------
	// register writes
	// ---------------------------------------------------------
	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
		begin
			feature_sel <= '0;
			queue_sel   <= '0;
			queue_num   <= '0;
			int_status  <= '0;
			for (int i = 0; i < QUEUE_NUM; i++)
				for (int j = 0; j < 7; j++)
					queue_tab[i][j] <= '0;
		end
		else if (wr_en)
		begin
			case (bank_req.addr)
				OFF_DEV_FEATURES_SEL: feature_sel <= bank_req.data;
				OFF_QUEUE_SEL:        queue_sel <= bank_req.data;
				OFF_QUEUE_NUM:        queue_num <= bank_req.data;
				// used buffer notification towards the driver
				OFF_QUEUE_NOTIFY:     int_status[0] <= 1'b1;
				OFF_INT_ACK:          int_status <= int_status & ~bank_req.data;
				default:
					if (slot_hit && sel_ok)
						queue_tab[sel_idx][slot] <= bank_req.data;
			endcase
		end
	end

	// ---------------------------------------------------------
	// read data, one cycle after the grant
	// ---------------------------------------------------------
	always_comb
	begin
		case (bank_req.addr)
			OFF_MAGIC:         rd_value = MAGIC_VALUE;
			OFF_VERSION:       rd_value = VERSION;
			OFF_DEVICE_ID:     rd_value = DEVICE_ID;
			OFF_VENDOR_ID:     rd_value = VENDOR_ID;
			OFF_DEV_FEATURES:  rd_value = feature_word;
			OFF_QUEUE_NUM_MAX: rd_value = QUEUE_NUM_MAX;
			OFF_QUEUE_NUM:     rd_value = queue_num;
			OFF_INT_STATUS:    rd_value = int_status;
			OFF_STATUS:        rd_value = device_status;
			OFF_CONFIG_GEN:    rd_value = CONFIG_GENERATION;
			OFF_CAPACITY_LO:   rd_value = SECTOR_COUNT[31:0];
			OFF_CAPACITY_HI:   rd_value = SECTOR_COUNT[63:32];
			default:           rd_value = slot_data;
		endcase
	end

	always_ff @(posedge axi_aclk)
	begin
		if (rd_en)
			bank_rdata <= rd_value;
	end

	always_ff @(posedge axi_aclk)
	begin
		if (!axi_aresetn)
			interrupt <= 1'b0;
		else
			interrupt <= int_status[0];
	end

endmodule

// File: vlog.f
source/virtio_mmio_pkg.sv
source/axi_write_engine.sv
source/axi_read_engine.sv
source/reg_arbiter.sv
source/device_status_fsm.sv
source/virtio_regs.sv
source/virtio_mmio_top.sv
sim/tb_virtio_mmio.sv
